// ==== mtrAcctCounters.sv ====
`timescale 1ns/1ns
module mtrAcctCounters (
  input  logic                          MBOX_CLK,
  input  logic                          RESET,
  input  mtrPkg::mtrConfig              cfg,
  input  mtrPkg::mtrClears              clears,
  input  mtrPkg::mtrEvents              events,
  output logic [mtrPkg::countWidth-1:0] eboxCount,
  output logic [mtrPkg::countWidth-1:0] cacheCount,
  output logic                          eboxWrap,
  output logic                          cacheWrap
);

  logic acctEn;
  logic eboxEn;
  logic halfCount;

  // Interrupt level work is charged only when both enables are set
  assign acctEn = cfg.acctOn &
                  (events.userMode | (events.piLevel == 3'd0) |
                   (cfg.piAcctEn & cfg.execAcctEn));
  assign eboxEn = acctEn & ~events.eboxWait;

  always_ff @(posedge MBOX_CLK or posedge RESET) begin
    if (RESET) begin
      cacheCount <= '0;
      cacheWrap <= 1'b0;
    end else begin
      cacheWrap <= 1'b0;
      if (clears.clrCache) begin
        cacheCount <= '0;
      end else if (acctEn && events.mbXfer) begin
        cacheCount <= cacheCount + 1'b1;
        cacheWrap <= &cacheCount;
      end
    end
  end

  // EBOX counts every second enabled cycle
  always_ff @(posedge MBOX_CLK or posedge RESET) begin
    if (RESET) begin
      halfCount <= 1'b0;
      eboxCount <= '0;
      eboxWrap <= 1'b0;
    end else begin
      eboxWrap <= 1'b0;
      if (clears.clrEbox) begin
        halfCount <= 1'b0;
        eboxCount <= '0;
      end else if (eboxEn) begin
        halfCount <= ~halfCount;
        if (halfCount) begin
          eboxCount <= eboxCount + 1'b1;
          eboxWrap <= &eboxCount;
        end
      end
    end
  end

endmodule

// ==== mtrIntervalTimer.sv ====
`timescale 1ns/1ns
module mtrIntervalTimer (
  input  logic                           MBOX_CLK,
  input  logic                           RESET,
  input  logic                           tick,
  input  logic                           intervalOn,
  input  logic [mtrPkg::periodWidth-1:0] period,
  input  logic                           clrInterval,
  output logic [mtrPkg::periodWidth-1:0] intervalCount,
  output logic                           intervalDone,
  output logic                           intervalOvf
);

  logic matchInh;
  logic match;

  // Zero period never matches
  assign match = (intervalCount == period) & (period != '0) & ~matchInh;

  always_ff @(posedge MBOX_CLK or posedge RESET) begin
    if (RESET) begin
      intervalCount <= '0;
      matchInh <= 1'b1;
      intervalDone <= 1'b0;
      intervalOvf <= 1'b0;
    end else begin
      intervalDone <= 1'b0;
      intervalOvf <= 1'b0;
      if (clrInterval) begin
        intervalCount <= '0;
        matchInh <= 1'b1;
      end else if (!intervalOn) begin
        // Skip matching on the first tick after enable
        matchInh <= 1'b1;
      end else if (tick) begin
        matchInh <= 1'b0;
        if (match) begin
          intervalCount <= '0;
          intervalDone <= 1'b1;
        end else begin
          intervalCount <= intervalCount + 1'b1;
          intervalOvf <= &intervalCount;
        end
      end
    end
  end

endmodule

// ==== mtrMeter.f ====
mtrPkg.sv
mtrRegs.sv
mtrTimeBase.sv
mtrAcctCounters.sv
mtrIntervalTimer.sv
mtrPerfCounter.sv
mtrMeter.sv
mtrMeter_props.sv
mtrTb.sv

// ==== mtrMeter.sv ====
`timescale 1ns/1ns
module mtrMeter (
  input  logic                         MBOX_CLK,
  input  logic                         RESET,
  input  logic                         pSel,
  input  logic                         pEnable,
  input  logic                         pWrite,
  input  logic [mtrPkg::addrWidth-1:0] pAddr,
  input  logic [mtrPkg::dataWidth-1:0] pWData,
  output logic [mtrPkg::dataWidth-1:0] pRData,
  output logic                         pReady,
  output logic                         pSlvErr,
  input  mtrPkg::mtrEvents             events,
  output logic                         interruptReq,
  output logic [2:0]                   pia
);

  mtrPkg::mtrConfig cfg;
  mtrPkg::mtrClears clears;
  wire mtrPkg::mtrCounts counts;
  wire mtrPkg::mtrWraps wraps;
  logic tick;

  assign pia = cfg.pia;

  mtrRegs mtrRegs_inst (
    .MBOX_CLK     (MBOX_CLK),
    .RESET        (RESET),
    .pSel         (pSel),
    .pEnable      (pEnable),
    .pWrite       (pWrite),
    .pAddr        (pAddr),
    .pWData       (pWData),
    .counts       (counts),
    .wraps        (wraps),
    .pRData       (pRData),
    .pReady       (pReady),
    .pSlvErr      (pSlvErr),
    .cfg          (cfg),
    .clears       (clears),
    .interruptReq (interruptReq)
  );

  mtrTimeBase mtrTimeBase_inst (
    .MBOX_CLK  (MBOX_CLK),
    .RESET     (RESET),
    .timeOn    (cfg.timeOn),
    .clrTime   (clears.clrTime),
    .tick      (tick),
    .timeCount (counts.timeCount),
    .timeWrap  (wraps.timeWrap)
  );

  mtrAcctCounters mtrAcctCounters_inst (
    .MBOX_CLK   (MBOX_CLK),
    .RESET      (RESET),
    .cfg        (cfg),
    .clears     (clears),
    .events     (events),
    .eboxCount  (counts.eboxCount),
    .cacheCount (counts.cacheCount),
    .eboxWrap   (wraps.eboxWrap),
    .cacheWrap  (wraps.cacheWrap)
  );

  mtrIntervalTimer mtrIntervalTimer_inst (
    .MBOX_CLK      (MBOX_CLK),
    .RESET         (RESET),
    .tick          (tick),
    .intervalOn    (cfg.intervalOn),
    .period        (cfg.period),
    .clrInterval   (clears.clrInterval),
    .intervalCount (counts.intervalCount),
    .intervalDone  (wraps.intervalDone),
    .intervalOvf   (wraps.intervalOvf)
  );

  mtrPerfCounter mtrPerfCounter_inst (
    .MBOX_CLK  (MBOX_CLK),
    .RESET     (RESET),
    .cfg       (cfg),
    .clrPerf   (clears.clrPerf),
    .events    (events),
    .perfCount (counts.perfCount),
    .perfWrap  (wraps.perfWrap)
  );

endmodule

// ==== mtrMeter_props.sv ====
`timescale 1ns/1ns
module mtrMeterProps (
  input logic       MBOX_CLK,
  input logic       RESET,
  input logic       pSel,
  input logic       pEnable,
  input logic       pReady,
  input logic       interruptReq,
  input logic [2:0] pia
);

  // Access phase only after a setup phase
  enableAfterSetup: assert property (
    @(posedge MBOX_CLK) disable iff (RESET)
      $rose(pEnable) |-> $past(pSel) && pSel
  ) else $error("pEnable rose without a setup phase");

  enableHoldsSel: assert property (
    @(posedge MBOX_CLK) disable iff (RESET) pEnable |-> pSel
  ) else $error("pEnable high while pSel is low");

  readyInAccess: assert property (
    @(posedge MBOX_CLK) disable iff (RESET) (pSel && pEnable) |-> pReady
  ) else $error("pReady low in an access phase");

  irqNeedsPia: assert property (
    @(posedge MBOX_CLK) disable iff (RESET) (pia == 3'd0) |-> !interruptReq
  ) else $error("interruptReq high with no PI assignment");

endmodule

bind mtrMeter mtrMeterProps mtrMeterProps_inst (
  .MBOX_CLK     (MBOX_CLK),
  .RESET        (RESET),
  .pSel         (pSel),
  .pEnable      (pEnable),
  .pReady       (pReady),
  .interruptReq (interruptReq),
  .pia          (pia)
);

// ==== mtrPerfCounter.sv ====
`timescale 1ns/1ns
module mtrPerfCounter (
  input  logic                          MBOX_CLK,
  input  logic                          RESET,
  input  mtrPkg::mtrConfig              cfg,
  input  logic                          clrPerf,
  input  mtrPkg::mtrEvents              events,
  output logic [mtrPkg::countWidth-1:0] perfCount,
  output logic                          perfWrap
);

  logic modeMatch;
  logic piMatch;
  logic cacheMatch;
  logic chanMatch;
  logic qual;
  logic qualPrev;
  logic countEn;

  assign modeMatch = (events.userMode == cfg.paSetup.piView.userEn) |
                     cfg.paSetup.piView.modeDontCare;

  // Level zero uses its own enable bit
  assign piMatch = (events.piLevel == 3'd0) ? cfg.paSetup.piView.noPiEn :
                   cfg.paSetup.piView.piEn[events.piLevel];

  assign cacheMatch = (events.eboxWait &
                       ((cfg.refEn & events.cacheRef) |
                        (cfg.fillEn & events.cacheFill) |
                        (cfg.ewbEn & events.eWriteback) |
                        (cfg.swbEn & events.sWriteback))) |
                      cfg.cacheDontCare;

  // Same low bits as piEn, read as channel enables
  assign chanMatch = (|(cfg.paSetup.chanView.chanEn[mtrPkg::chanCount-1:0] &
                        events.chanBusy)) |
                     cfg.paSetup.chanView.chanDontCare;

  assign qual = modeMatch & piMatch & cacheMatch & chanMatch;

  // Event mode counts rising edges, duration mode counts cycles
  assign countEn = cfg.paSetup.piView.eventMode ? (qual & ~qualPrev) : qual;

  always_ff @(posedge MBOX_CLK or posedge RESET) begin
    if (RESET) begin
      qualPrev <= 1'b0;
      perfCount <= '0;
      perfWrap <= 1'b0;
    end else begin
      qualPrev <= qual;
      perfWrap <= 1'b0;
      if (clrPerf) begin
        perfCount <= '0;
      end else if (countEn) begin
        perfCount <= perfCount + 1'b1;
        perfWrap <= &perfCount;
      end
    end
  end

endmodule

// ==== mtrPkg.sv ====
package mtrPkg;

  localparam int countWidth = 17;
  localparam int periodWidth = 12;
  // MBOX_CLK cycles per 1 MHz tick, scaled down for simulation
  localparam int tickDivide = 10;
  localparam int tickWidth = $clog2(tickDivide);
  localparam logic [tickWidth-1:0] tickLast = tickWidth'(tickDivide - 1);
  localparam int chanCount = 4;

  localparam int addrWidth = 8;
  localparam int dataWidth = 32;

  localparam logic [addrWidth-1:0] ctlAddr      = 8'h00;
  localparam logic [addrWidth-1:0] clrAddr      = 8'h04;
  localparam logic [addrWidth-1:0] intervalAddr = 8'h08;
  localparam logic [addrWidth-1:0] paRightAddr  = 8'h0C;
  localparam logic [addrWidth-1:0] paLeftAddr   = 8'h10;
  localparam logic [addrWidth-1:0] timeAddr     = 8'h14;
  localparam logic [addrWidth-1:0] eboxAddr     = 8'h18;
  localparam logic [addrWidth-1:0] cacheAddr    = 8'h1C;
  localparam logic [addrWidth-1:0] perfAddr     = 8'h20;
  localparam logic [addrWidth-1:0] intCountAddr = 8'h24;
  localparam logic [addrWidth-1:0] statusAddr   = 8'h28;

  // PI-level view of the setup word
  typedef struct packed {
    logic       eventMode;
    logic       modeDontCare;
    logic       userEn;
    logic       noPiEn;
    logic [7:0] piEn;
  } mtrPiView;

  // Channel view, low byte shared with piEn
  typedef struct packed {
    logic [2:0] spare;
    logic       chanDontCare;
    logic [7:0] chanEn;
  } mtrChanView;

  typedef union packed {
    mtrPiView   piView;
    mtrChanView chanView;
  } mtrPaSetup;

  typedef struct packed {
    logic                   acctOn;
    logic                   piAcctEn;
    logic                   execAcctEn;
    logic                   timeOn;
    logic [2:0]             pia;
    logic                   intervalOn;
    logic [periodWidth-1:0] period;
    mtrPaSetup              paSetup;
    logic                   refEn;
    logic                   fillEn;
    logic                   ewbEn;
    logic                   swbEn;
    logic                   cacheDontCare;
  } mtrConfig;

  typedef struct packed {
    logic clrTime;
    logic clrEbox;
    logic clrCache;
    logic clrPerf;
    logic clrInterval;
  } mtrClears;

  typedef struct packed {
    logic                 mbXfer;
    logic                 eboxWait;
    logic                 userMode;
    logic [2:0]           piLevel;
    logic                 cacheRef;
    logic                 cacheFill;
    logic                 eWriteback;
    logic                 sWriteback;
    logic [chanCount-1:0] chanBusy;
  } mtrEvents;

  typedef struct packed {
    logic [countWidth-1:0]  timeCount;
    logic [countWidth-1:0]  eboxCount;
    logic [countWidth-1:0]  cacheCount;
    logic [countWidth-1:0]  perfCount;
    logic [periodWidth-1:0] intervalCount;
  } mtrCounts;

  // Status bit 5 is timeWrap, bit 0 is intervalOvf
  typedef struct packed {
    logic timeWrap;
    logic eboxWrap;
    logic cacheWrap;
    logic perfWrap;
    logic intervalDone;
    logic intervalOvf;
  } mtrWraps;

endpackage

// ==== mtrRegs.sv ====
`timescale 1ns/1ns
module mtrRegs (
  input  logic                          MBOX_CLK,
  input  logic                          RESET,
  input  logic                          pSel,
  input  logic                          pEnable,
  input  logic                          pWrite,
  input  logic [mtrPkg::addrWidth-1:0]  pAddr,
  input  logic [mtrPkg::dataWidth-1:0]  pWData,
  input  mtrPkg::mtrCounts              counts,
  input  mtrPkg::mtrWraps               wraps,
  output logic [mtrPkg::dataWidth-1:0]  pRData,
  output logic                          pReady,
  output logic                          pSlvErr,
  output mtrPkg::mtrConfig              cfg,
  output mtrPkg::mtrClears              clears,
  output logic                          interruptReq
);

  logic       access;
  logic       writeEn;
  logic       addrValid;
  logic [5:0] clearMask;
  logic [5:0] statusFlags;
  logic       irqPending;

  assign access = pSel & pEnable;
  assign writeEn = access & pWrite;
  assign pReady = 1'b1;
  assign pSlvErr = access & ~addrValid;

  // Write-1-to-clear mask for the status flags
  assign clearMask = (writeEn && pAddr == mtrPkg::statusAddr) ? pWData[5:0] : 6'b0;

  always_comb begin
    pRData = '0;
    addrValid = 1'b1;
    case (pAddr)
      mtrPkg::ctlAddr:
        pRData[7:0] = {cfg.intervalOn, cfg.pia, cfg.timeOn,
                       cfg.execAcctEn, cfg.piAcctEn, cfg.acctOn};
      mtrPkg::clrAddr:
        pRData = '0;
      mtrPkg::intervalAddr:
        pRData[mtrPkg::periodWidth-1:0] = cfg.period;
      mtrPkg::paRightAddr:
        pRData[11:0] = cfg.paSetup;
      mtrPkg::paLeftAddr:
        pRData[4:0] = {cfg.cacheDontCare, cfg.swbEn, cfg.ewbEn, cfg.fillEn, cfg.refEn};
      mtrPkg::timeAddr:
        pRData[mtrPkg::countWidth-1:0] = counts.timeCount;
      mtrPkg::eboxAddr:
        pRData[mtrPkg::countWidth-1:0] = counts.eboxCount;
      mtrPkg::cacheAddr:
        pRData[mtrPkg::countWidth-1:0] = counts.cacheCount;
      mtrPkg::perfAddr:
        pRData[mtrPkg::countWidth-1:0] = counts.perfCount;
      mtrPkg::intCountAddr:
        pRData[mtrPkg::periodWidth-1:0] = counts.intervalCount;
      mtrPkg::statusAddr:
        pRData[5:0] = statusFlags;
      default:
        addrValid = 1'b0;
    endcase
  end

  always_ff @(posedge MBOX_CLK or posedge RESET) begin
    if (RESET) begin
      cfg <= '0;
      clears <= '0;
    end else begin
      // Strobes last one cycle
      clears <= '0;
      if (writeEn) begin
        case (pAddr)
          mtrPkg::ctlAddr: begin
            cfg.acctOn <= pWData[0];
            cfg.piAcctEn <= pWData[1];
            cfg.execAcctEn <= pWData[2];
            cfg.timeOn <= pWData[3];
            cfg.pia <= pWData[6:4];
            cfg.intervalOn <= pWData[7];
          end
          mtrPkg::clrAddr: begin
            clears.clrTime <= pWData[0];
            clears.clrEbox <= pWData[1];
            clears.clrCache <= pWData[2];
            clears.clrPerf <= pWData[3];
            clears.clrInterval <= pWData[4];
          end
          mtrPkg::intervalAddr:
            cfg.period <= pWData[mtrPkg::periodWidth-1:0];
          mtrPkg::paRightAddr:
            cfg.paSetup <= pWData[11:0];
          mtrPkg::paLeftAddr: begin
            cfg.refEn <= pWData[0];
            cfg.fillEn <= pWData[1];
            cfg.ewbEn <= pWData[2];
            cfg.swbEn <= pWData[3];
            cfg.cacheDontCare <= pWData[4];
          end
          default: begin
            // Count, status and unmapped addresses hold no config
            cfg <= cfg;
          end
        endcase
      end
    end
  end

  // A new wrap in the same cycle beats the clear
  always_ff @(posedge MBOX_CLK or posedge RESET) begin
    if (RESET) begin
      statusFlags <= '0;
      irqPending <= 1'b0;
    end else begin
      statusFlags <= (statusFlags & ~clearMask) | wraps;
      irqPending <= |statusFlags;
    end
  end

  // No PI assignment means no request
  assign interruptReq = irqPending & (|cfg.pia);

endmodule

// ==== mtrTb.sv ====
`timescale 1ns/1ns
module mtrTb;

  localparam string traceFile = "mtrTrace.txt";
  // Sample point inside the access phase, clear of both clock edges
  localparam int sampleDelay = 2;
  // Lowest bit of the PI assignment in the control register
  localparam int piaLsb = 4;

  logic                         MBOX_CLK;
  logic                         RESET;
  logic                         pSel;
  logic                         pEnable;
  logic                         pWrite;
  logic [mtrPkg::addrWidth-1:0] pAddr;
  logic [mtrPkg::dataWidth-1:0] pWData;
  logic [mtrPkg::dataWidth-1:0] pRData;
  logic                         pReady;
  logic                         pSlvErr;
  mtrPkg::mtrEvents             events;
  logic                         interruptReq;
  logic [2:0]                   pia;

  int cycleCount = 0;
  int cycleLimit = 0;
  int errorCount = 0;
  int checkCount = 0;
  int testCount = 0;
  int errorsAtStart = 0;

  mtrMeter mtrMeter_inst (
    .MBOX_CLK     (MBOX_CLK),
    .RESET        (RESET),
    .pSel         (pSel),
    .pEnable      (pEnable),
    .pWrite       (pWrite),
    .pAddr        (pAddr),
    .pWData       (pWData),
    .pRData       (pRData),
    .pReady       (pReady),
    .pSlvErr      (pSlvErr),
    .events       (events),
    .interruptReq (interruptReq),
    .pia          (pia)
  );

  always #5 MBOX_CLK = ~MBOX_CLK;

  always @(posedge MBOX_CLK) begin
    cycleCount = cycleCount + 1;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin
      $display("Timeout: trace not finished within %0d cycles", cycleLimit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic reportMismatch(input string signal, input logic [31:0] expected,
                                input logic [31:0] got);
    errorCount++;
    $display("FAILED at %0t ns: %0s expected %h got %h", $time, signal, expected, got);
  endtask

  // Entered and left on a falling edge
  task automatic apbAccess(input logic write, input logic [7:0] addr,
                           input logic [31:0] data, output logic [31:0] rdata,
                           output logic err);
    pSel = 1'b1;
    pWrite = write;
    pAddr = addr;
    pWData = data;
    pEnable = 1'b0;
    @(negedge MBOX_CLK);
    pEnable = 1'b1;
    #sampleDelay;
    while (!pReady) begin
      @(negedge MBOX_CLK);
      #sampleDelay;
    end
    rdata = pRData;
    err = pSlvErr;
    @(negedge MBOX_CLK);
    pSel = 1'b0;
    pEnable = 1'b0;
    pWrite = 1'b0;
  endtask

  task automatic checkRead(input logic [7:0] addr, input logic [31:0] expected,
                           input logic [31:0] tol);
    logic [31:0] got;
    logic err;
    logic [31:0] diff;
    apbAccess(1'b0, addr, '0, got, err);
    checkCount++;
    diff = (got > expected) ? got - expected : expected - got;
    if ($isunknown(got) || diff > tol) begin
      reportMismatch($sformatf("pRData@%h", addr), expected, got);
    end
    if (err !== 1'b0) begin
      reportMismatch($sformatf("pSlvErr@%h", addr), 32'd0, {31'd0, err});
    end
  endtask

  task automatic checkSlvErr(input logic [7:0] addr);
    logic [31:0] got;
    logic err;
    apbAccess(1'b0, addr, '0, got, err);
    checkCount++;
    if (err !== 1'b1) begin
      reportMismatch($sformatf("pSlvErr@%h", addr), 32'd1, {31'd0, err});
    end
  endtask

  task automatic checkIrq(input logic expected);
    checkCount++;
    if (interruptReq !== expected) begin
      reportMismatch("interruptReq", {31'd0, expected}, {31'd0, interruptReq});
    end
  endtask

  task automatic checkPia(input logic [2:0] expected);
    checkCount++;
    if (pia !== expected) begin
      reportMismatch("pia", {29'd0, expected}, {29'd0, pia});
    end
  endtask

  task automatic driveEvents(input logic [31:0] value, input int cycles);
    events = value[$bits(events)-1:0];
    repeat (cycles) @(negedge MBOX_CLK);
  endtask

  task automatic endTest(input logic [8*32-1:0] name);
    testCount++;
    if (errorCount == errorsAtStart) begin
      $display("Test %0s: ok", name);
    end else begin
      $display("Test %0s: %0d errors", name, errorCount - errorsAtStart);
    end
    errorsAtStart = errorCount;
  endtask

  // Limit is hold cycles plus 20 per command plus 100
  task automatic measureTrace();
    int fd;
    int code;
    int commands;
    int holdSum;
    int cycles;
    logic [7:0] cmd;
    logic [31:0] value;
    logic [8*128-1:0] rest;
    commands = 0;
    holdSum = 0;
    fd = $fopen(traceFile, "r");
    if (fd == 0) begin
      cycleLimit = 100;
      return;
    end
    while ($fscanf(fd, "%s", cmd) == 1) begin
      if (cmd == "E") begin
        code = $fscanf(fd, "%h %d", value, cycles);
        holdSum += cycles;
        commands++;
      end else begin
        if (cmd != "#") begin
          commands++;
        end
        code = $fgets(rest, fd);
      end
    end
    $fclose(fd);
    cycleLimit = holdSum + 20 * commands + 100;
  endtask

  task automatic runTrace();
    int fd;
    int code;
    int cycles;
    logic [7:0] cmd;
    logic [31:0] arg1;
    logic [31:0] arg2;
    logic [31:0] arg3;
    logic [31:0] unusedData;
    logic unusedErr;
    logic [8*32-1:0] name;
    logic [8*128-1:0] rest;
    fd = $fopen(traceFile, "r");
    if (fd == 0) begin
      $display("Cannot open trace file %0s", traceFile);
      errorCount++;
      return;
    end
    while ($fscanf(fd, "%s", cmd) == 1) begin
      case (cmd)
        "#": code = $fgets(rest, fd);
        "W": begin
          code = $fscanf(fd, "%h %h", arg1, arg2);
          apbAccess(1'b1, arg1[7:0], arg2, unusedData, unusedErr);
          // The PI assignment output follows the control register
          if (arg1[7:0] == mtrPkg::ctlAddr) begin
            checkPia(arg2[piaLsb+2:piaLsb]);
          end
        end
        "R": begin
          code = $fscanf(fd, "%h %h %h", arg1, arg2, arg3);
          checkRead(arg1[7:0], arg2, arg3);
        end
        "U": begin
          code = $fscanf(fd, "%h", arg1);
          checkSlvErr(arg1[7:0]);
        end
        "E": begin
          code = $fscanf(fd, "%h %d", arg1, cycles);
          driveEvents(arg1, cycles);
        end
        "I": begin
          code = $fscanf(fd, "%h", arg1);
          checkIrq(arg1[0]);
        end
        "T": begin
          code = $fscanf(fd, "%s", name);
          endTest(name);
        end
        default: begin
          $display("Unknown trace command %c in %0s", cmd, traceFile);
          errorCount++;
          code = $fgets(rest, fd);
        end
      endcase
    end
    $fclose(fd);
  endtask

  initial begin
    MBOX_CLK = 1'b0;
    RESET = 1'b1;
    pSel = 1'b0;
    pEnable = 1'b0;
    pWrite = 1'b0;
    pAddr = '0;
    pWData = '0;
    events = '0;
    measureTrace();
    repeat (5) @(posedge MBOX_CLK);
    @(negedge MBOX_CLK);
    RESET = 1'b0;
    runTrace();
    $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== mtrTimeBase.sv ====
`timescale 1ns/1ns
module mtrTimeBase (
  input  logic                          MBOX_CLK,
  input  logic                          RESET,
  input  logic                          timeOn,
  input  logic                          clrTime,
  output logic                          tick,
  output logic [mtrPkg::countWidth-1:0] timeCount,
  output logic                          timeWrap
);

  logic [mtrPkg::tickWidth-1:0] prescale;

  assign tick = prescale == mtrPkg::tickLast;

  // Free-running prescaler, restarted by a time clear
  always_ff @(posedge MBOX_CLK or posedge RESET) begin
    if (RESET) begin
      prescale <= '0;
    end else if (clrTime || tick) begin
      prescale <= '0;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

  always_ff @(posedge MBOX_CLK or posedge RESET) begin
    if (RESET) begin
      timeCount <= '0;
      timeWrap <= 1'b0;
    end else begin
      timeWrap <= 1'b0;
      if (clrTime) begin
        timeCount <= '0;
      end else if (tick && timeOn) begin
        timeCount <= timeCount + 1'b1;
        timeWrap <= &timeCount;
      end
    end
  end

endmodule

// ==== mtrTrace.txt ====
# W addr data | R addr expected tolerance | U addr (expect pSlvErr) | all hex
# E events(hex) holdCycles(dec) | I interruptReq | T testName
E 1000 1
W 08 5A5
R 08 5A5 0
W 0C ABC
R 0C ABC 0
W 10 15
R 10 15 0
W 00 76
R 00 76 0
U 30
U 2C
W 00 0
T registers
# timeOn, clear, then about 200 cycles
W 00 08
W 04 01
E 1000 200
W 00 00
R 14 14 1
T timeBase
# acctOn with piLevel 0, then piLevel 3 with piAcctEn clear
W 00 01
W 04 06
E 1000 2
E 2000 40
E 1000 2
R 1C 28 0
R 18 14 1
E 2300 30
E 1000 2
R 1C 28 0
R 18 14 1
W 00 00
T accounting
# period 3, pia 2
W 08 003
W 00 A0
W 04 10
E 1000 80
R 28 02 0
I 1
W 00 20
W 28 02
E 1000 2
R 28 00 0
I 0
W 00 00
T interval
# idle is piLevel 1, driven level is 2
E 1100 1
W 10 10
W 0C 504
W 04 08
E 1100 2
E 1200 25
E 1100 2
R 20 19 0
T perfDuration
W 0C 500
W 04 08
E 1100 2
E 1200 25
E 1100 2
R 20 0 0
T perfMasked
W 0C D04
W 04 08
E 1100 2
E 1200 3
E 1100 2
E 1200 1
E 1100 4
E 1200 5
E 1100 2
R 20 3 0
T perfEvent
# setup 406 enables levels 1 and 2 and channels 1 and 2
W 0C 406
W 04 08
E 1100 2
E 1201 20
E 1208 10
E 1202 15
E 1100 2
R 20 F 0
T perfChannel

// ==== run.sh ====
#!/bin/sh
# Build and run the meter board testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module mtrTb -f mtrMeter.f -o mtrSim
output=$(./obj_dir/mtrSim)
echo "$output"
if echo "$output" | grep -qx "Simulation PASSED"; then
  exit 0
fi
exit 1
